//--- pe_consts.svh
`ifndef PE_CONSTS_SVH
`define PE_CONSTS_SVH

// Data widths
`define PE_IF_WIDTH 8
`define PE_FILT_WIDTH 8

// Scratchpad depths
`define PE_IF_DEPTH 32
`define PE_FILT_DEPTH 16

// Address widths
`define PE_IF_ADDR_LEN 5
`define PE_FILT_ADDR_LEN 4

// Product width plus one carry bit
`define PE_PSUM_WIDTH (`PE_IF_WIDTH + `PE_FILT_WIDTH + 1)

`endif

//--- pe_pkg.sv
`include "pe_consts.svh"

package pe_pkg;

    typedef logic [`PE_IF_WIDTH-1:0] ifmap_t;
    typedef logic [`PE_FILT_WIDTH-1:0] filt_t;
    typedef logic [`PE_IF_ADDR_LEN-1:0] if_addr_t;
    typedef logic [`PE_FILT_ADDR_LEN-1:0] filt_addr_t;

    // Wraps on overflow
    typedef logic [`PE_PSUM_WIDTH-1:0] psum_t;

    // Head word of the ifmap buffer
    typedef struct packed {
        ifmap_t data;
        logic   last;
    } if_buf_word_t;

    // Per-tap control from the address generator to the MAC
    typedef struct packed {
        logic valid;
        logic first;
        logic last;
    } tap_ctl_t;

endpackage

//--- scratch_mem.sv
`timescale 1ns/100ps

module scratch_mem #(
    parameter type word_t = logic [7:0],
    parameter type addr_t = logic [4:0],
    parameter int  depth  = 32
) (
    input  logic  clk,
    input  logic  wen,
    input  addr_t waddr,
    input  addr_t raddr,
    input  logic  ren,
    input  word_t din,
    output word_t dout
);

    word_t mem [depth];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= din;
        end
        // Output only moves on ren so a stall keeps it
        if (ren) begin
            dout <= mem[raddr];
        end
    end

    a_waddr_range: assert property (
        @(posedge clk) wen |-> ($unsigned(waddr) < depth)
    ) else $error("scratch_mem write address %0d beyond depth %0d", waddr, depth);

endmodule

//--- ifmap_reader.sv
`timescale 1ns/100ps

module ifmap_reader (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  pe_pkg::if_buf_word_t buf_word,
    input  logic                 buf_empty,
    output logic                 buf_read,
    output logic                 scratch_wen,
    output pe_pkg::if_addr_t     waddr,
    output pe_pkg::if_addr_t     last_addr,
    output logic                 if_valid
);

    typedef enum logic {
        st_idle,
        st_load
    } state_t;

    state_t           state;
    pe_pkg::if_addr_t wptr;

    // Head word is written in the same cycle it is popped
    assign buf_read    = (state == st_load) && !buf_empty;
    assign scratch_wen = buf_read;
    assign waddr       = wptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            wptr      <= '0;
            last_addr <= '0;
            if_valid  <= 1'b0;
        end else if (start) begin
            state    <= st_load;
            wptr     <= '0;
            if_valid <= 1'b0;
        end else if (buf_read) begin
            wptr <= wptr + 1'b1;
            // End of row
            if (buf_word.last) begin
                state     <= st_idle;
                last_addr <= wptr;
                if_valid  <= 1'b1;
            end
        end
    end

    // Row must fit in the scratchpad
    a_row_fits: assert property (
        @(posedge clk) disable iff (rst) (buf_read && (wptr == '1)) |-> buf_word.last
    ) else $error("ifmap row longer than the scratchpad");

endmodule

//--- filter_reader.sv
`timescale 1ns/100ps

module filter_reader (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  pe_pkg::filt_addr_t filt_len,
    input  pe_pkg::filt_t      buf_data,
    input  logic               buf_empty,
    output logic               buf_read,
    output logic               scratch_wen,
    output pe_pkg::filt_addr_t waddr,
    output logic               filt_ready
);

    logic               loading;
    pe_pkg::filt_addr_t cnt;
    pe_pkg::filt_addr_t len_q;
    logic               last_tap;

    assign buf_read    = loading && !buf_empty;
    assign scratch_wen = buf_read;
    assign waddr       = cnt;
    assign last_tap    = (cnt == len_q - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            loading    <= 1'b0;
            cnt        <= '0;
            len_q      <= '0;
            filt_ready <= 1'b0;
        end else if (start) begin
            loading    <= 1'b1;
            cnt        <= '0;
            len_q      <= filt_len;
            filt_ready <= 1'b0;
        end else if (buf_read) begin
            if (last_tap) begin
                loading    <= 1'b0;
                filt_ready <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

//--- read_addr_gen.sv
`timescale 1ns/100ps
`include "pe_consts.svh"

module read_addr_gen (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  pe_pkg::if_addr_t   stride_len,
    input  pe_pkg::filt_addr_t filt_len,
    input  pe_pkg::if_addr_t   if_last_addr,
    input  logic               if_valid,
    input  logic               filt_ready,
    input  logic               stall,
    output pe_pkg::if_addr_t   if_raddr,
    output pe_pkg::filt_addr_t filt_raddr,
    output logic               read_en,
    output pe_pkg::tap_ctl_t   tap,
    output logic               all_issued
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_run
    } state_t;

    state_t                     state;
    pe_pkg::if_addr_t           base;
    pe_pkg::if_addr_t           stride_q;
    pe_pkg::filt_addr_t         k;
    pe_pkg::filt_addr_t         len_q;
    logic                       last_tap;
    logic                       all_issued_q;
    logic [`PE_IF_ADDR_LEN+1:0] nxt_end;

    assign last_tap = (k == len_q - 1'b1);
    // Last address of the following window, kept wide so it cannot wrap
    assign nxt_end  = base + stride_q + len_q - 1'b1;

    assign read_en    = (state == st_run) && !stall;
    assign if_raddr   = base + k;
    assign filt_raddr = k;
    assign tap        = '{valid: read_en, first: (k == '0), last: last_tap};
    assign all_issued = all_issued_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= st_idle;
            base         <= '0;
            k            <= '0;
            all_issued_q <= 1'b0;
        end else begin
            all_issued_q <= 1'b0;
            if (start) begin
                state    <= st_wait;
                base     <= '0;
                k        <= '0;
                stride_q <= stride_len;
                len_q    <= filt_len;
            end else begin
                case (state)
                    st_wait: begin
                        if (if_valid && filt_ready) begin
                            if (len_q - 1'b1 <= if_last_addr) begin
                                state <= st_run;
                            end else begin
                                state        <= st_idle;
                                all_issued_q <= 1'b1;
                            end
                        end
                    end
                    st_run: begin
                        if (!stall && !last_tap) begin
                            k <= k + 1'b1;
                        end else if (!stall) begin
                            k <= '0;
                            if (nxt_end <= if_last_addr) begin
                                base <= base + stride_q;
                            end else begin
                                state        <= st_idle;
                                all_issued_q <= 1'b1;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Every tap reads a word that the ifmap reader has written
    a_tap_in_row: assert property (
        @(posedge clk) disable iff (rst) read_en |-> (if_raddr <= if_last_addr)
    ) else $error("tap read address %0d beyond last ifmap address %0d",
                  if_raddr, if_last_addr);

endmodule

//--- mac_unit.sv
`timescale 1ns/100ps
`include "pe_consts.svh"

module mac_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  pe_pkg::tap_ctl_t tap,
    input  pe_pkg::ifmap_t   if_data,
    input  pe_pkg::filt_t    filt_data,
    input  pe_pkg::psum_t    psum_in,
    input  logic             psum_in_en,
    output pe_pkg::psum_t    sum,
    output logic             sum_valid
);

    // Stage 1 lines up with the scratchpad outputs, stage 2 with the product
    pe_pkg::tap_ctl_t tap_s1;
    pe_pkg::tap_ctl_t tap_s2;
    logic             sum_valid_q;

    logic [`PE_IF_WIDTH+`PE_FILT_WIDTH-1:0] prod_q;
    pe_pkg::psum_t                          acc_q;
    pe_pkg::psum_t                          acc_base;

    // First tap of a window restarts from zero or the external partial sum
    assign acc_base = tap_s2.first ? (psum_in_en ? psum_in : '0) : acc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            tap_s1      <= '0;
            tap_s2      <= '0;
            sum_valid_q <= 1'b0;
        end else if (!stall) begin
            tap_s1      <= tap;
            tap_s2      <= tap_s1;
            sum_valid_q <= tap_s2.valid && tap_s2.last;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            prod_q <= if_data * filt_data;
            if (tap_s2.valid) begin
                acc_q <= acc_base + pe_pkg::psum_t'(prod_q);
            end
        end
    end

    assign sum       = acc_q;
    assign sum_valid = sum_valid_q;

endmodule

//--- outbuf_writer.sv
`timescale 1ns/100ps

module outbuf_writer (
    input  logic          clk,
    input  logic          rst,
    input  pe_pkg::psum_t sum,
    input  logic          sum_valid,
    input  logic          all_issued,
    input  logic          outbuf_full,
    output logic          outbuf_write,
    output pe_pkg::psum_t outbuf_data,
    output logic          stall,
    output logic          full_done
);

    logic          held_q;
    pe_pkg::psum_t data_q;
    logic          take;
    logic          issued_seen;
    // Unstalled cycles before the last window's sum reaches sum_valid
    logic [1:0]    pend_cnt;
    logic          full_done_q;

    assign outbuf_write = held_q && !outbuf_full;
    assign stall        = held_q && outbuf_full;
    assign take         = sum_valid && !stall;
    assign outbuf_data  = data_q;
    assign full_done    = full_done_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            held_q      <= 1'b0;
            issued_seen <= 1'b0;
            pend_cnt    <= '0;
            full_done_q <= 1'b0;
        end else begin
            if (take) begin
                held_q <= 1'b1;
            end else if (outbuf_write) begin
                held_q <= 1'b0;
            end
            full_done_q <= 1'b0;
            if (all_issued) begin
                issued_seen <= 1'b1;
                pend_cnt    <= stall ? 2'd2 : 2'd1;
            end else if (issued_seen && pend_cnt != '0) begin
                if (!stall) begin
                    pend_cnt <= pend_cnt - 1'b1;
                end
            end else if (issued_seen && !sum_valid && (!held_q || outbuf_write)) begin
                full_done_q <= 1'b1;
                issued_seen <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            data_q <= sum;
        end
    end

    // Nothing left in flight when the run is reported done
    a_done_drained: assert property (
        @(posedge clk) disable iff (rst)
        full_done |-> (!held_q && !sum_valid)
    ) else $error("full_done raised while a sum was still pending");

endmodule

//--- pe_datapath.sv
`timescale 1ns/100ps
`include "pe_consts.svh"

module pe_datapath (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ifmap_start,
    input  logic                 filter_start,
    input  logic                 conv_start,
    input  pe_pkg::if_addr_t     stride_len,
    input  pe_pkg::filt_addr_t   filt_len,
    input  pe_pkg::if_buf_word_t if_buf_word,
    input  logic                 if_buf_empty,
    output logic                 if_buf_read,
    input  pe_pkg::filt_t        filt_buf_data,
    input  logic                 filt_buf_empty,
    output logic                 filt_buf_read,
    input  pe_pkg::psum_t        psum_in,
    input  logic                 psum_in_en,
    input  logic                 outbuf_full,
    output logic                 outbuf_write,
    output pe_pkg::psum_t        outbuf_data,
    output logic                 full_done
);

    logic               if_wen;
    pe_pkg::if_addr_t   if_waddr;
    pe_pkg::if_addr_t   if_last_addr;
    logic               if_valid;
    logic               filt_wen;
    pe_pkg::filt_addr_t filt_waddr;
    logic               filt_ready;
    pe_pkg::if_addr_t   if_raddr;
    pe_pkg::filt_addr_t filt_raddr;
    logic               read_en;
    pe_pkg::tap_ctl_t   tap;
    logic               all_issued;
    pe_pkg::ifmap_t     if_dout;
    pe_pkg::filt_t      filt_dout;
    pe_pkg::psum_t      sum;
    logic               sum_valid;
    logic               stall;

    ifmap_reader u_if_reader (
        .clk(clk), .rst(rst), .start(ifmap_start),
        .buf_word(if_buf_word), .buf_empty(if_buf_empty), .buf_read(if_buf_read),
        .scratch_wen(if_wen), .waddr(if_waddr),
        .last_addr(if_last_addr), .if_valid(if_valid)
    );

    filter_reader u_filt_reader (
        .clk(clk), .rst(rst), .start(filter_start), .filt_len(filt_len),
        .buf_data(filt_buf_data), .buf_empty(filt_buf_empty), .buf_read(filt_buf_read),
        .scratch_wen(filt_wen), .waddr(filt_waddr), .filt_ready(filt_ready)
    );

    scratch_mem #(
        .word_t(pe_pkg::ifmap_t), .addr_t(pe_pkg::if_addr_t), .depth(`PE_IF_DEPTH)
    ) u_if_scratch (
        .clk(clk), .wen(if_wen), .waddr(if_waddr), .raddr(if_raddr),
        .ren(read_en), .din(if_buf_word.data), .dout(if_dout)
    );

    scratch_mem #(
        .word_t(pe_pkg::filt_t), .addr_t(pe_pkg::filt_addr_t), .depth(`PE_FILT_DEPTH)
    ) u_filt_scratch (
        .clk(clk), .wen(filt_wen), .waddr(filt_waddr), .raddr(filt_raddr),
        .ren(read_en), .din(filt_buf_data), .dout(filt_dout)
    );

    read_addr_gen u_addr_gen (
        .clk(clk), .rst(rst), .start(conv_start),
        .stride_len(stride_len), .filt_len(filt_len),
        .if_last_addr(if_last_addr), .if_valid(if_valid), .filt_ready(filt_ready),
        .stall(stall), .if_raddr(if_raddr), .filt_raddr(filt_raddr),
        .read_en(read_en), .tap(tap), .all_issued(all_issued)
    );

    mac_unit u_mac (
        .clk(clk), .rst(rst), .stall(stall), .tap(tap),
        .if_data(if_dout), .filt_data(filt_dout),
        .psum_in(psum_in), .psum_in_en(psum_in_en),
        .sum(sum), .sum_valid(sum_valid)
    );

    outbuf_writer u_out_writer (
        .clk(clk), .rst(rst), .sum(sum), .sum_valid(sum_valid),
        .all_issued(all_issued), .outbuf_full(outbuf_full),
        .outbuf_write(outbuf_write), .outbuf_data(outbuf_data),
        .stall(stall), .full_done(full_done)
    );

endmodule

//--- tb_pe_tasks.svh
function automatic int count_taps(input int n, input int len, input int stride);
    return ((n - len) / stride + 1) * len;
endfunction

task automatic abort_run(input string msg);
    $display("ERROR: %s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped");
endtask

task automatic check_equal(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        $display("Test failed");
        $fatal(1, "simulation stopped at first mismatch");
    end
endtask

// Window w covers row[w*stride .. w*stride+len-1] and must end inside the row
task automatic compute_expected(input int n, input int len, input int stride,
                                input logic psum_en, input pe_pkg::psum_t psum);
    pe_pkg::psum_t acc;
    int            w;
    int            k;
    exp_q.delete();
    w = 0;
    while (w * stride + len - 1 <= n - 1) begin
        acc = psum_en ? psum : '0;
        for (k = 0; k < len; k++) begin
            acc = acc + pe_pkg::psum_t'(row_data[w * stride + k])
                      * pe_pkg::psum_t'(filt_data[k]);
        end
        exp_q.push_back(acc);
        w++;
    end
endtask

task automatic wait_run_done(input string name, input int limit);
    int cycles;
    cycles = 0;
    while (done_cnt == 0 && cycles < limit) begin
        @(negedge clk);
        cycles++;
    end
    if (done_cnt == 0) begin
        abort_run($sformatf("%s: full_done never pulsed after the last window", name));
    end else begin
        repeat (4) @(negedge clk);
        #1;
        gaps_on      = 1'b0;
        full_rand_on = 1'b0;
    end
endtask

task automatic check_results(input string name);
    int i;
    check_equal($sformatf("%s sum count", name), exp_q.size(), got_q.size());
    for (i = 0; i < exp_q.size(); i++) begin
        check_equal($sformatf("%s window %0d", name, i), exp_q[i], got_q[i]);
    end
    check_equal($sformatf("%s full_done pulses", name), 1, done_cnt);
    check_equal($sformatf("%s full_done cycle", name), last_write_cycle + 1, done_cycle);
    // Every word handed to the element has been taken
    check_equal($sformatf("%s ifmap words left", name), 0, if_q.size());
    check_equal($sformatf("%s filter taps left", name), 0, filt_q.size());
endtask

task automatic run_conv(input string name, input int shape, input logic psum_en,
                        input logic gaps, input logic full_rand);
    int                   n;
    int                   len;
    int                   stride;
    int                   i;
    pe_pkg::if_buf_word_t word;
    pe_pkg::psum_t        psum;
    n      = shape_n[shape];
    len    = shape_len[shape];
    stride = shape_stride[shape];
    @(negedge clk);
    #1;
    for (i = 0; i < n; i++) begin
        row_data[i] = pe_pkg::ifmap_t'($random(seed));
        word.data   = row_data[i];
        word.last   = (i == n - 1);
        if_q.push_back(word);
    end
    for (i = 0; i < len; i++) begin
        filt_data[i] = pe_pkg::filt_t'($random(seed));
        filt_q.push_back(filt_data[i]);
    end
    psum = pe_pkg::psum_t'($random(seed));
    compute_expected(n, len, stride, psum_en, psum);
    got_q.delete();
    done_cnt     = 0;
    gaps_on      = gaps;
    full_rand_on = full_rand;
    @(negedge clk);
    stride_len   = pe_pkg::if_addr_t'(stride);
    filt_len     = pe_pkg::filt_addr_t'(len);
    psum_in      = psum;
    psum_in_en   = psum_en;
    ifmap_start  = 1'b1;
    filter_start = 1'b1;
    @(negedge clk);
    ifmap_start  = 1'b0;
    filter_start = 1'b0;
    conv_start   = 1'b1;
    @(negedge clk);
    conv_start = 1'b0;
    wait_run_done(name, count_taps(n, len, stride) * 20 + n * 4 + 50);
    check_results(name);
endtask

task automatic test_stride1();
    run_conv("stride1", 0, 1'b0, 1'b0, 1'b0);
endtask

// Odd row, so the last window ends exactly on the last word
task automatic test_stride2();
    run_conv("stride2", 1, 1'b0, 1'b0, 1'b0);
endtask

task automatic test_psum_in();
    run_conv("psum_in", 2, 1'b1, 1'b0, 1'b0);
endtask

task automatic test_backpressure();
    run_conv("backpressure", 3, 1'b0, 1'b0, 1'b1);
endtask

task automatic test_input_gaps();
    run_conv("input_gaps", 4, 1'b0, 1'b1, 1'b0);
endtask

// Shorter row and longer filter than the run before
task automatic test_reload();
    run_conv("reload", 5, 1'b0, 1'b0, 1'b0);
endtask

//--- tb_pe_datapath.sv
`timescale 1ns/100ps
`include "pe_consts.svh"

module tb_pe_datapath;

    logic                 clk;
    logic                 rst;
    logic                 ifmap_start;
    logic                 filter_start;
    logic                 conv_start;
    pe_pkg::if_addr_t     stride_len;
    pe_pkg::filt_addr_t   filt_len;
    pe_pkg::if_buf_word_t if_buf_word;
    logic                 if_buf_empty;
    logic                 if_buf_read;
    pe_pkg::filt_t        filt_buf_data;
    logic                 filt_buf_empty;
    logic                 filt_buf_read;
    pe_pkg::psum_t        psum_in;
    logic                 psum_in_en;
    logic                 outbuf_full;
    logic                 outbuf_write;
    pe_pkg::psum_t        outbuf_data;
    logic                 full_done;

    // Row length, filter length and stride of each run
    localparam int shape_n[6]      = '{10, 13, 12, 16, 14, 9};
    localparam int shape_len[6]    = '{3, 5, 4, 3, 3, 4};
    localparam int shape_stride[6] = '{1, 2, 1, 1, 1, 2};

    integer seed;
    logic   gaps_on;
    logic   full_rand_on;
    int     cycle_cnt;
    int     last_write_cycle;
    int     done_cycle;
    int     done_cnt;

    pe_pkg::if_buf_word_t if_q[$];
    pe_pkg::filt_t        filt_q[$];
    pe_pkg::psum_t        got_q[$];
    pe_pkg::psum_t        exp_q[$];
    pe_pkg::ifmap_t       row_data [`PE_IF_DEPTH];
    pe_pkg::filt_t        filt_data [`PE_FILT_DEPTH];
    logic                 if_gap;
    logic                 filt_gap;

    pe_datapath uut (.*);

    `include "tb_pe_tasks.svh"

    always #10 clk = ~clk;

    // Buffer heads, empty levels and output back-pressure
    always @(negedge clk) begin
        if_gap   = gaps_on ? (($random(seed) & 3) == 0) : 1'b0;
        filt_gap = gaps_on ? (($random(seed) & 3) == 0) : 1'b0;
        if (if_q.size() > 0) begin
            if_buf_word = if_q[0];
        end
        if (filt_q.size() > 0) begin
            filt_buf_data = filt_q[0];
        end
        if_buf_empty   = (if_q.size() == 0) || if_gap;
        filt_buf_empty = (filt_q.size() == 0) || filt_gap;
        outbuf_full    = full_rand_on ? (($random(seed) & 1) != 0) : 1'b0;
    end

    // Pops of the FWFT buffers
    always @(posedge clk) begin
        if (if_buf_read && if_q.size() == 0) begin
            abort_run("ifmap buffer popped while it held no word");
        end else if (filt_buf_read && filt_q.size() == 0) begin
            abort_run("filter buffer popped while it held no word");
        end else begin
            if (if_buf_read) begin
                void'(if_q.pop_front());
            end
            if (filt_buf_read) begin
                void'(filt_q.pop_front());
            end
        end
    end

    // Output buffer side
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (!rst && outbuf_write && outbuf_full) begin
            abort_run("output buffer written while it was full");
        end else if (!rst) begin
            if (outbuf_write) begin
                got_q.push_back(outbuf_data);
                last_write_cycle = cycle_cnt;
            end
            if (full_done) begin
                done_cnt   = done_cnt + 1;
                done_cycle = cycle_cnt;
            end
        end
    end

    initial begin
        int total;
        int s;
        total = 0;
        for (s = 0; s < 6; s++) begin
            total = total + count_taps(shape_n[s], shape_len[s], shape_stride[s]);
        end
        repeat (total * 20 + 1000) @(posedge clk);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        seed           = 32'h131a_a585;
        clk            = 1'b0;
        rst            = 1'b1;
        ifmap_start    = 1'b0;
        filter_start   = 1'b0;
        conv_start     = 1'b0;
        stride_len     = '0;
        filt_len       = '0;
        if_buf_word    = '0;
        if_buf_empty   = 1'b1;
        filt_buf_data  = '0;
        filt_buf_empty = 1'b1;
        psum_in        = '0;
        psum_in_en     = 1'b0;
        outbuf_full    = 1'b0;
        gaps_on        = 1'b0;
        full_rand_on   = 1'b0;
        cycle_cnt      = 0;
        done_cnt       = 0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        test_stride1();
        test_stride2();
        test_psum_in();
        test_backpressure();
        test_input_gaps();
        test_reload();
        $display("Test passed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
pe_pkg.sv
scratch_mem.sv
ifmap_reader.sv
filter_reader.sv
read_addr_gen.sv
mac_unit.sv
outbuf_writer.sv
pe_datapath.sv
tb_pe_datapath.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -f sim.log \
    && verilator --binary --timing --assert -Wno-fatal --top-module tb_pe_datapath -f vlog.f \
    && ./obj_dir/Vtb_pe_datapath > sim.log 2>&1
grep -qx "Test passed" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
